// ==== logic/frameBuffer.sv ====
`default_nettype none

module frameBuffer
    import panelPkg::*;
(
    input  wire                      ClockA,
    input  wire                      rst,
    input  wire                      hostWr,
    input  wire  [ByteAddrWidth-1:0] hostAddr,
    input  wire  [7:0]               hostData,
    input  wire                      readStrobe,
    input  wire  [WordAddrWidth-1:0] readAddr,
    output logic [31:0]              pairData,
    output logic                     pairValid
);

    logic [7:0] mem [0:FrameBytes-1];

    // first read stage, straight out of the array
    logic [31:0] pairPre;

    // strobe travels alongside the data
    logic [ReadLatency-1:0] validPipe;

    // host side, one byte per strobe
    always_ff @(posedge ClockA) begin
        if (hostWr) begin
            mem[hostAddr] <= hostData;
        end
    end

    // lower half in the upper 16 bits, low byte of each pixel first
    always_ff @(posedge ClockA) begin
        pairPre  <= {mem[{1'b1, readAddr, 1'b1}],
                     mem[{1'b1, readAddr, 1'b0}],
                     mem[{1'b0, readAddr, 1'b1}],
                     mem[{1'b0, readAddr, 1'b0}]};
        pairData <= pairPre;
    end

    always_ff @(posedge ClockA) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[ReadLatency-2:0], readStrobe};
        end
    end

    assign pairValid = validPipe[ReadLatency-1];

    // a write to an unknown address would corrupt an arbitrary pixel
    hostAddrKnown: assert property (
        @(posedge ClockA) disable iff (rst)
        hostWr |-> !$isunknown(hostAddr)
    ) else $error("hostAddr has unknown bits during a write");

endmodule

`default_nettype wire

// ==== logic/panelDriver.sv ====
`default_nettype none

module panelDriver
    import panelPkg::*;
(
    input  wire                      ClockA,
    input  wire                      rst,
    input  wire                      hostWr,
    input  wire  [ByteAddrWidth-1:0] hostAddr,
    input  wire  [7:0]               hostData,
    output logic [2:0]               rgbTop,
    output logic [2:0]               rgbBottom,
    output logic                     panelClk,
    output logic                     panelLatch,
    output logic                     panelBlank,
    output logic [RowWidth-1:0]      rowAddr
);

    // sequencer to timer
    logic colClear;
    logic colStep;
    logic displayLoad;
    logic displayStep;
    logic scanAdvance;

    // timer to sequencer, buffer and shifter
    logic [ColWidth-1:0]   col;
    logic                  colLast;
    logic [RowWidth-1:0]   row;
    logic [PlaneWidth-1:0] plane;
    logic                  displayDone;

    // read path
    logic        readStrobe;
    logic [31:0] pairData;
    logic        pairValid;

    frameBuffer frameBuffer_i (
        .ClockA     (ClockA),
        .rst        (rst),
        .hostWr     (hostWr),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .readStrobe (readStrobe),
        .readAddr   ({row, col}),
        .pairData   (pairData),
        .pairValid  (pairValid)
    );

    scanTimer scanTimer_i (
        .ClockA      (ClockA),
        .rst         (rst),
        .colClear    (colClear),
        .colStep     (colStep),
        .displayLoad (displayLoad),
        .displayStep (displayStep),
        .scanAdvance (scanAdvance),
        .col         (col),
        .colLast     (colLast),
        .row         (row),
        .plane       (plane),
        .displayDone (displayDone)
    );

    panelSequencer panelSequencer_i (
        .ClockA      (ClockA),
        .rst         (rst),
        .colLast     (colLast),
        .row         (row),
        .displayDone (displayDone),
        .colClear    (colClear),
        .colStep     (colStep),
        .readStrobe  (readStrobe),
        .displayLoad (displayLoad),
        .displayStep (displayStep),
        .scanAdvance (scanAdvance),
        .panelLatch  (panelLatch),
        .panelBlank  (panelBlank),
        .rowAddr     (rowAddr)
    );

    pixelShifter pixelShifter_i (
        .ClockA    (ClockA),
        .rst       (rst),
        .pairValid (pairValid),
        .pairData  (pairData),
        .plane     (plane),
        .rgbTop    (rgbTop),
        .rgbBottom (rgbBottom),
        .panelClk  (panelClk)
    );

endmodule

`default_nettype wire

// ==== logic/panelPkg.sv ====
`default_nettype none

package panelPkg;

    // panel geometry, two halves scanned in parallel
    localparam int PanelWidth      = 64;
    localparam int PanelHalfHeight = 16;
    localparam int BytesPerPixel   = 2;
    localparam int FrameBytes      = 2 * PanelHalfHeight * PanelWidth * BytesPerPixel;

    // byte address is {half, row, col, byte}
    localparam int ByteAddrWidth = $clog2(FrameBytes);
    // read address is {row, col}, both halves fetched together
    localparam int WordAddrWidth = ByteAddrWidth - 2;
    localparam int ColWidth      = $clog2(PanelWidth);
    localparam int RowWidth      = $clog2(PanelHalfHeight);

    // five binary-weighted bit planes per channel
    localparam int PlaneCount = 5;
    localparam int PlaneWidth = 3;

    // lsb of the plane bits inside an RGB565 word
    // green skips its lowest bit so all channels get five planes
    localparam int RedLsb   = 11;
    localparam int GreenLsb = 6;
    localparam int BlueLsb  = 0;

    // plane p is lit for BaseDisplayCycles << p cycles
    localparam int BaseDisplayCycles = 4;
    localparam int DisplayWidth      = 7;

    // read address to pair data, and read address to panelClk
    localparam int ReadLatency  = 2;
    localparam int ShiftLatency = 3;

    typedef enum logic [2:0] {
        ScanIdle,
        ScanShift,
        ScanDrain,
        ScanLatch,
        ScanDisplay
    } scanState;

endpackage

`default_nettype wire

// ==== logic/panelSequencer.sv ====
`default_nettype none

module panelSequencer
    import panelPkg::*;
(
    input  wire                 ClockA,
    input  wire                 rst,
    input  wire                 colLast,
    input  wire  [RowWidth-1:0] row,
    input  wire                 displayDone,
    output logic                colClear,
    output logic                colStep,
    output logic                readStrobe,
    output logic                displayLoad,
    output logic                displayStep,
    output logic                scanAdvance,
    output logic                panelLatch,
    output logic                panelBlank,
    output logic [RowWidth-1:0] rowAddr
);

    scanState state;
    scanState nextState;

    // drain waits for the last reads to reach the panel
    logic [1:0] drainCount;

    always_comb begin
        nextState = state;
        case (state)
            ScanIdle:    nextState = ScanShift;
            ScanShift:   if (colLast) nextState = ScanDrain;
            ScanDrain:   if (drainCount == 2'(ShiftLatency - 1)) nextState = ScanLatch;
            ScanLatch:   nextState = ScanDisplay;
            ScanDisplay: if (displayDone) nextState = ScanShift;
            default:     nextState = ScanIdle;
        endcase
    end

    always_ff @(posedge ClockA) begin
        if (rst) begin
            state      <= ScanIdle;
            drainCount <= '0;
        end else begin
            state <= nextState;
            if (state == ScanDrain) begin
                drainCount <= drainCount + 1'b1;
            end else begin
                drainCount <= '0;
            end
        end
    end

    // one read per column while shifting
    assign colClear    = (state != ScanShift);
    assign colStep     = (state == ScanShift);
    assign readStrobe  = (state == ScanShift);
    assign displayLoad = (state == ScanLatch);
    assign displayStep = (state == ScanDisplay);
    assign scanAdvance = (state == ScanDisplay) && displayDone;

    // panel controls follow the state they belong to, cycle-exact
    always_ff @(posedge ClockA) begin
        if (rst) begin
            panelLatch <= 1'b0;
            panelBlank <= 1'b1;
            rowAddr    <= '0;
        end else begin
            panelLatch <= (nextState == ScanLatch);
            panelBlank <= (nextState != ScanDisplay);
            if (nextState == ScanLatch) begin
                rowAddr <= row;
            end
        end
    end

    latchSingle: assert property (
        @(posedge ClockA) disable iff (rst)
        panelLatch |=> !panelLatch
    ) else $error("panelLatch high for two cycles");

    // latching with LEDs lit shows a torn row
    latchBlanked: assert property (
        @(posedge ClockA) disable iff (rst)
        panelLatch |-> panelBlank
    ) else $error("panelLatch while panelBlank low");

endmodule

`default_nettype wire

// ==== logic/pixelShifter.sv ====
`default_nettype none

module pixelShifter
    import panelPkg::*;
(
    input  wire                   ClockA,
    input  wire                   rst,
    input  wire                   pairValid,
    input  wire  [31:0]           pairData,
    input  wire  [PlaneWidth-1:0] plane,
    output logic [2:0]            rgbTop,
    output logic [2:0]            rgbBottom,
    output logic                  panelClk
);

    // red, green, blue bits of one plane from an RGB565 word
    function automatic logic [2:0] planeBits(
        input logic [15:0]           pixel,
        input logic [PlaneWidth-1:0] p
    );
        logic [2:0] bits;
        bits[2] = pixel[RedLsb + p];
        bits[1] = pixel[GreenLsb + p];
        bits[0] = pixel[BlueLsb + p];
        return bits;
    endfunction

    logic [2:0] topBits;
    logic [2:0] bottomBits;

    assign topBits    = planeBits(pairData[15:0], plane);
    assign bottomBits = planeBits(pairData[31:16], plane);

    // colour lines only change with a pulse
    always_ff @(posedge ClockA) begin
        if (pairValid) begin
            rgbTop    <= topBits;
            rgbBottom <= bottomBits;
        end
    end

    always_ff @(posedge ClockA) begin
        if (rst) begin
            panelClk <= 1'b0;
        end else begin
            panelClk <= pairValid;
        end
    end

    // plane may only move between passes, never under a fetched pair
    planeSteady: assert property (
        @(posedge ClockA) disable iff (rst)
        pairValid |-> $stable(plane)
    ) else $error("plane changed while a pixel pair was in flight");

endmodule

`default_nettype wire

// ==== logic/scanTimer.sv ====
`default_nettype none

module scanTimer
    import panelPkg::*;
(
    input  wire                   ClockA,
    input  wire                   rst,
    input  wire                   colClear,
    input  wire                   colStep,
    input  wire                   displayLoad,
    input  wire                   displayStep,
    input  wire                   scanAdvance,
    output logic [ColWidth-1:0]   col,
    output logic                  colLast,
    output logic [RowWidth-1:0]   row,
    output logic [PlaneWidth-1:0] plane,
    output logic                  displayDone
);

    logic [DisplayWidth-1:0] displayCount;

    // column counter, clear wins over step
    always_ff @(posedge ClockA) begin
        if (rst || colClear) begin
            col <= '0;
        end else if (colStep) begin
            col <= col + 1'b1;
        end
    end

    assign colLast = (col == ColWidth'(PanelWidth - 1));

    // plane runs fastest, row steps when the plane wraps
    always_ff @(posedge ClockA) begin
        if (rst) begin
            row   <= '0;
            plane <= '0;
        end else if (scanAdvance) begin
            if (plane == PlaneWidth'(PlaneCount - 1)) begin
                plane <= '0;
                row   <= row + 1'b1;
            end else begin
                plane <= plane + 1'b1;
            end
        end
    end

    // counts N down to 1 so done marks the last lit cycle
    always_ff @(posedge ClockA) begin
        if (rst) begin
            displayCount <= '0;
        end else if (displayLoad) begin
            displayCount <= DisplayWidth'(BaseDisplayCycles) << plane;
        end else if (displayStep && displayCount != '0) begin
            displayCount <= displayCount - 1'b1;
        end
    end

    assign displayDone = (displayCount == DisplayWidth'(1));

endmodule

`default_nettype wire

// ==== project.f ====
logic/panelPkg.sv
logic/frameBuffer.sv
logic/scanTimer.sv
logic/panelSequencer.sv
logic/pixelShifter.sv
logic/panelDriver.sv
test/panelMonitor.sv
test/panelDriverTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module panelDriverTb -f project.f &&
./obj_dir/VpanelDriverTb | tee /dev/stderr | grep -q "Testbench passed" ||
exit 1

// ==== test/panelDriverTb.sv ====
`default_nettype none

module panelDriverTb
    import panelPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    logic                     ClockA;
    logic                     rst;
    logic                     hostWr;
    logic [ByteAddrWidth-1:0] hostAddr;
    logic [7:0]               hostData;
    logic [2:0]               rgbTop;
    logic [2:0]               rgbBottom;
    logic                     panelClk;
    logic                     panelLatch;
    logic                     panelBlank;
    logic [RowWidth-1:0]      rowAddr;
    logic                     checkEnable;

    int pixelErrors;
    int sequenceErrors;
    int timingErrors;
    int checkedPixels;
    int timeouts;
    logic [31:0] lcgState;

    panelDriver panelDriver_i (
        .ClockA     (ClockA),
        .rst        (rst),
        .hostWr     (hostWr),
        .hostAddr   (hostAddr),
        .hostData   (hostData),
        .rgbTop     (rgbTop),
        .rgbBottom  (rgbBottom),
        .panelClk   (panelClk),
        .panelLatch (panelLatch),
        .panelBlank (panelBlank),
        .rowAddr    (rowAddr)
    );

    panelMonitor panelMonitor_i (
        .ClockA         (ClockA),
        .rst            (rst),
        .checkEnable    (checkEnable),
        .hostWr         (hostWr),
        .hostAddr       (hostAddr),
        .hostData       (hostData),
        .rgbTop         (rgbTop),
        .rgbBottom      (rgbBottom),
        .panelClk       (panelClk),
        .panelLatch     (panelLatch),
        .panelBlank     (panelBlank),
        .rowAddr        (rowAddr),
        .pixelErrors    (pixelErrors),
        .sequenceErrors (sequenceErrors),
        .timingErrors   (timingErrors),
        .checkedPixels  (checkedPixels)
    );

    initial begin
        ClockA = 1'b0;
        forever begin
            #4 ClockA = ~ClockA;
        end
    end

    // upper half of the LCG state has the better bits
    function automatic logic [15:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[31:16];
    endfunction

    task automatic fillFrame();
        logic        firstHalf;
        logic [15:0] r;
        r = nextRandom();
        firstHalf = r[8];
        for (int h = 0; h < 2; h++) begin
            for (int i = 0; i < FrameBytes / 2; i++) begin
                r = nextRandom();
                @(posedge ClockA);
                hostWr   <= 1'b1;
                hostAddr <= {firstHalf ^ h[0], i[ByteAddrWidth-2:0]};
                hostData <= r[15:8];
            end
        end
        @(posedge ClockA);
        hostWr <= 1'b0;
    endtask

    task automatic waitForLatch(
        input logic                anyRow,
        input logic [RowWidth-1:0] row,
        input int                  limit
    );
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(posedge ClockA);
            cycles++;
            if (panelLatch && (anyRow || rowAddr == row)) begin
                found = 1'b1;
            end
        end
        if (!found) begin
            $display("Timeout: no panelLatch for rowAddr %0d within %0d cycles", row, limit);
            timeouts++;
        end
    endtask

    task automatic waitForBlankHigh(input int limit);
        int   cycles;
        logic found;
        cycles = 0;
        found  = 1'b0;
        while (!found && cycles < limit) begin
            @(posedge ClockA);
            cycles++;
            found = panelBlank;
        end
        if (!found) begin
            $display("Timeout: panelBlank stayed low for %0d cycles", limit);
            timeouts++;
        end
    endtask

    // random byte writes while the LEDs are lit
    task automatic runLiveFrames(input int latchTarget, input int limit);
        int                  latches;
        int                  idle;
        logic [15:0]         r;
        logic [15:0]         d;
        logic [RowWidth-1:0] row;
        latches = 0;
        idle    = 0;
        while (latches < latchTarget && idle < limit) begin
            @(posedge ClockA);
            idle++;
            if (panelLatch) begin
                latches++;
                idle = 0;
            end
            r = nextRandom();
            d = nextRandom();
            if (!panelBlank && r[1:0] == 2'b00) begin
                // skip the lit row and the row that may be shifted next
                row = rowAddr + RowWidth'(2) + RowWidth'(r[15:12] % 14);
                hostWr   <= 1'b1;
                hostAddr <= {r[11], row, r[10:5], r[4]};
                hostData <= d[15:8];
            end else begin
                hostWr <= 1'b0;
            end
        end
        hostWr <= 1'b0;
        if (latches < latchTarget) begin
            $display("Timeout: only %0d of %0d latches seen during live writes",
                     latches, latchTarget);
            timeouts++;
        end
    endtask

    initial begin
        lcgState    = 32'd56;
        rst         = 1'b1;
        hostWr      = 1'b0;
        hostAddr    = '0;
        hostData    = '0;
        checkEnable = 1'b0;
        timeouts    = 0;
        repeat (2) @(posedge ClockA);
        rst <= 1'b0;

        fillFrame();

        // first latch of row 15, then its remaining planes, then the frame start
        waitForLatch(1'b0, RowWidth'(14), 10000);
        if (timeouts == 0) begin
            waitForLatch(1'b0, RowWidth'(15), 1000);
        end
        for (int i = 1; i < PlaneCount; i++) begin
            if (timeouts == 0) begin
                waitForLatch(1'b1, '0, 300);
            end
        end
        if (timeouts == 0) begin
            waitForBlankHigh(300);
        end
        if (timeouts == 0) begin
            checkEnable <= 1'b1;
            runLiveFrames(2 * PlaneCount * PanelHalfHeight, 300);
        end
        if (timeouts == 0) begin
            waitForBlankHigh(300);
        end
        repeat (2) @(posedge ClockA);
        #1;

        $display("Errors: pixel %0d, sequence %0d, timing %0d, timeouts %0d (%0d pixels checked)",
                 pixelErrors, sequenceErrors, timingErrors, timeouts, checkedPixels);
        if (pixelErrors == 0 && sequenceErrors == 0 && timingErrors == 0 && timeouts == 0
            && checkedPixels > 0) begin
            $display("Testbench passed");
        end else begin
            if (checkedPixels == 0) begin
                $display("No pixel was compared against the frame model");
            end
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/panelMonitor.sv ====
`default_nettype none

module panelMonitor
    import panelPkg::*;
(
    input  wire                      ClockA,
    input  wire                      rst,
    input  wire                      checkEnable,
    input  wire                      hostWr,
    input  wire  [ByteAddrWidth-1:0] hostAddr,
    input  wire  [7:0]               hostData,
    input  wire  [2:0]               rgbTop,
    input  wire  [2:0]               rgbBottom,
    input  wire                      panelClk,
    input  wire                      panelLatch,
    input  wire                      panelBlank,
    input  wire  [RowWidth-1:0]      rowAddr,
    output int                       pixelErrors,
    output int                       sequenceErrors,
    output int                       timingErrors,
    output int                       checkedPixels
);
    timeunit 1ns;
    timeprecision 1ps;

    // byte image of the frame as the host wrote it
    logic [7:0] model [0:FrameBytes-1];

    int passCount;
    int pulseCount;
    int lowCount;
    int expectedLow;
    logic prevRst;
    logic prevLatch;
    logic prevBlank;
    logic [RowWidth-1:0] passRow;
    logic [PlaneWidth-1:0] passPlane;
    logic [ColWidth-1:0] column;
    logic [2:0] topExpected;
    logic [2:0] bottomExpected;

    function automatic logic [15:0] modelPixel(
        input logic                half,
        input logic [RowWidth-1:0] row,
        input logic [ColWidth-1:0] col
    );
        logic [ByteAddrWidth-1:0] lowAddr;
        logic [ByteAddrWidth-1:0] highAddr;
        lowAddr  = {half, row, col, 1'b0};
        highAddr = {half, row, col, 1'b1};
        return {model[highAddr], model[lowAddr]};
    endfunction

    // plane p takes bit p of the top five bits of each RGB565 channel
    function automatic logic [2:0] expectedColour(
        input logic [15:0]           pixel,
        input logic [PlaneWidth-1:0] p
    );
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
        red   = pixel[15:11];
        green = pixel[10:6];
        blue  = pixel[4:0];
        return {red[p], green[p], blue[p]};
    endfunction

    // compares one colour bus and names the pixel on a mismatch
    task automatic comparePixel(
        input string      name,
        input logic [2:0] expected,
        input logic [2:0] actual
    );
        if (actual !== expected) begin
            $display("Error at %0d ns: %s expected %b actual %b (row %0d col %0d plane %0d)",
                     $time, name, expected, actual, passRow, column, passPlane);
            pixelErrors++;
        end
    endtask

    always @(posedge ClockA) begin
        if (hostWr) begin
            model[hostAddr] <= hostData;
        end
    end

    always @(posedge ClockA) begin
        if (rst) begin
            passCount      = 0;
            pulseCount     = 0;
            lowCount       = 0;
            expectedLow    = 0;
            prevRst        = 1'b1;
            prevLatch      = 1'b0;
            prevBlank      = 1'b1;
            pixelErrors    = 0;
            sequenceErrors = 0;
            timingErrors   = 0;
            checkedPixels  = 0;
        end else begin
            // row and plane of the pass now being shifted
            passRow   = RowWidth'((passCount / PlaneCount) % PanelHalfHeight);
            passPlane = PlaneWidth'(passCount % PlaneCount);

            if (prevRst) begin
                if (panelClk !== 1'b0 || panelLatch !== 1'b0) begin
                    $display(
                        "Error at %0d ns: panelClk/panelLatch expected 0/0 actual %b/%b",
                        $time, panelClk, panelLatch);
                    sequenceErrors++;
                end
                if (panelBlank !== 1'b1 || rowAddr !== '0) begin
                    $display(
                        "Error at %0d ns: panelBlank/rowAddr expected 1/0 actual %b/%0d",
                        $time, panelBlank, rowAddr);
                    sequenceErrors++;
                end
            end

            if (panelClk) begin
                if (!panelBlank) begin
                    $display("At %0d ns a panelClk pulse arrived while the LEDs were lit",
                             $time);
                    timingErrors++;
                end
                if (checkEnable && pulseCount < PanelWidth) begin
                    column         = ColWidth'(pulseCount);
                    topExpected    = expectedColour(modelPixel(1'b0, passRow, column), passPlane);
                    bottomExpected = expectedColour(modelPixel(1'b1, passRow, column), passPlane);
                    comparePixel("rgbTop", topExpected, rgbTop);
                    comparePixel("rgbBottom", bottomExpected, rgbBottom);
                    checkedPixels++;
                end
                pulseCount++;
            end

            if (panelLatch) begin
                if (pulseCount != PanelWidth) begin
                    $display("Error at %0d ns: panelClk pulses per pass expected %0d actual %0d",
                             $time, PanelWidth, pulseCount);
                    sequenceErrors++;
                end
                if (rowAddr !== passRow) begin
                    $display("Error at %0d ns: rowAddr expected %0d actual %0d",
                             $time, passRow, rowAddr);
                    sequenceErrors++;
                end
                expectedLow = BaseDisplayCycles << passPlane;
                passCount++;
                pulseCount = 0;
            end

            // lit window opens right after the latch and closes on the rising blank
            if (prevLatch && panelBlank) begin
                $display("At %0d ns panelBlank did not go low in the cycle after panelLatch",
                         $time);
                timingErrors++;
            end
            if (!panelBlank) begin
                lowCount++;
            end else if (!prevBlank) begin
                if (lowCount != expectedLow) begin
                    $display("Error at %0d ns: panelBlank low cycles expected %0d actual %0d",
                             $time, expectedLow, lowCount);
                    timingErrors++;
                end
                lowCount = 0;
            end

            prevRst   = 1'b0;
            prevLatch = panelLatch;
            prevBlank = panelBlank;
        end
    end

endmodule

`default_nettype wire
